/* Makefile */
# Verilator build and run for the line upscaler testbench.

VERILATOR    ?= verilator
TOP          ?= tb_line_upscaler
MULT_LATENCY ?= 2
FILELIST     ?= sim.f
OBJ_DIR      ?= obj_dir_lat$(MULT_LATENCY)
VFLAGS       ?= --binary --timing --assert -j 0
PASS_TEXT    := *** PASSED ***

SOURCES := $(wildcard hw/*.sv verif/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# one build directory per latency, so a change of latency gives its own binary
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	    -GMULT_LATENCY=$(MULT_LATENCY) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	    echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf obj_dir_lat*

/* hw/bicubic_coef_pkg.sv */
package bicubic_coef_pkg;

    localparam int COEF_WIDTH = 12;  // signed coefficient width.
    localparam int FRAC_BITS  = 11;  // weights are in units of 1/2048.
    localparam int NUM_TAPS   = 4;
    localparam int NUM_PHASES = 5;   // outputs per input interval.

    typedef logic [2:0] coef_code_t;
    typedef logic [2:0] phase_t;

    typedef struct packed {
        coef_code_t tap0;
        coef_code_t tap1;
        coef_code_t tap2;
        coef_code_t tap3;
    } tap_codes_t;

    localparam coef_code_t C_M21   = 3'd0;
    localparam coef_code_t C_M135  = 3'd1;
    localparam coef_code_t C_M147  = 3'd2;
    localparam coef_code_t C_M225  = 3'd3;
    localparam coef_code_t C_P235  = 3'd4;
    localparam coef_code_t C_P873  = 3'd5;
    localparam coef_code_t C_P1535 = 3'd6;
    localparam coef_code_t C_P1981 = 3'd7;

    function automatic logic signed [COEF_WIDTH-1:0] coef_value(input coef_code_t code);
        case (code)
            C_M21:   return COEF_WIDTH'(-21);
            C_M135:  return COEF_WIDTH'(-135);
            C_M147:  return COEF_WIDTH'(-147);
            C_M225:  return COEF_WIDTH'(-225);
            C_P235:  return COEF_WIDTH'(235);
            C_P873:  return COEF_WIDTH'(873);
            C_P1535: return COEF_WIDTH'(1535);
            default: return COEF_WIDTH'(1981);  // the only code left is 7.
        endcase
    endfunction

    function automatic tap_codes_t phase_taps(input phase_t phase);
        case (phase)
            3'd1:    return '{tap0: C_M21, tap1: C_P1981, tap2: C_P235, tap3: C_M147};
            3'd2:    return '{tap0: C_M135, tap1: C_P1535, tap2: C_P873, tap3: C_M225};
            3'd3:    return '{tap0: C_M225, tap1: C_P873, tap2: C_P1535, tap3: C_M135};
            3'd4:    return '{tap0: C_M147, tap1: C_P235, tap2: C_P1981, tap3: C_M21};
            default: return '0;  // phase 0 bypasses the multipliers.
        endcase
    endfunction

endpackage

/* hw/bicubic_mult_config.sv */
`timescale 1ns/1ns

module bicubic_mult_config #(
    parameter int MULT_LATENCY  = 2,
    parameter int PRODUCT_WIDTH = 24
) (
    input  logic                            clk,
    input  bicubic_coef_pkg::coef_code_t    code,
    input  logic signed [PRODUCT_WIDTH-9:0] pixel,
    output logic signed [PRODUCT_WIDTH-1:0] product
);

    import bicubic_coef_pkg::*;

    logic signed [COEF_WIDTH-1:0]    coef;
    logic signed [PRODUCT_WIDTH-1:0] product_data;

    assign coef         = coef_value(code);
    assign product_data = coef * pixel;  // both operands sign extend to the product width.

    generate
        if (MULT_LATENCY == 1) begin : g_comb
            assign product = product_data;
        end else begin : g_pipe
            logic signed [PRODUCT_WIDTH-1:0] pipe [MULT_LATENCY-1];

            // models a multicycle hard multiplier, so no reset on the data.
            always_ff @(posedge clk) begin
                pipe[0] <= product_data;
                for (int i = 1; i < MULT_LATENCY - 1; i++) begin
                    pipe[i] <= pipe[i-1];
                end
            end

            assign product = pipe[MULT_LATENCY-2];
        end
    endgenerate

    initial begin
        assert (MULT_LATENCY >= 1 && MULT_LATENCY <= 3)
            else $fatal(1, "bicubic_mult_config: MULT_LATENCY %0d is outside 1 to 3.",
                        MULT_LATENCY);
    end

endmodule

/* hw/line_stream_pkg.sv */
package line_stream_pkg;

    localparam int PIXEL_W = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // one input pixel with its line markers.
    typedef struct packed {
        logic   valid;
        logic   sol;
        logic   eol;
        pixel_t data;
    } pixel_in_s;

    typedef struct packed {
        logic   valid;
        logic   eol;    // set on the last output of a line only.
        pixel_t data;
    } pixel_out_s;

    // w1 is the left pixel of the interval being interpolated.
    typedef struct packed {
        pixel_t w0;
        pixel_t w1;
        pixel_t w2;
        pixel_t w3;
    } window_s;

endpackage

/* hw/line_upscaler_top.sv */
`timescale 1ns/1ns

module line_upscaler_top #(
    parameter int MULT_LATENCY  = 2,
    parameter int PRODUCT_WIDTH = 24
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  line_stream_pkg::pixel_in_s  pix_in,
    output line_stream_pkg::pixel_out_s pix_out,
    output logic                        busy
);

    import bicubic_coef_pkg::*;
    import line_stream_pkg::*;

    logic    load_sol;
    logic    shift_pixel;
    logic    shift_rep;
    logic    run;
    logic    clear;
    logic    issue;
    logic    issue_eol;
    logic    phase_last;
    phase_t  phase;
    window_s window;

    upscale_ctrl #(
        .MULT_LATENCY (MULT_LATENCY)
    ) i_upscale_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_in      (pix_in),
        .phase_last  (phase_last),
        .phase       (phase),
        .load_sol    (load_sol),
        .shift_pixel (shift_pixel),
        .shift_rep   (shift_rep),
        .run         (run),
        .clear       (clear),
        .issue       (issue),
        .issue_eol   (issue_eol),
        .busy        (busy)
    );

    phase_counter i_phase_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .clear      (clear),
        .phase      (phase),
        .phase_last (phase_last)
    );

    tap_window i_tap_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (pix_in.data),
        .load_sol    (load_sol),
        .shift_pixel (shift_pixel),
        .shift_rep   (shift_rep),
        .window      (window)
    );

    tap_accumulator #(
        .MULT_LATENCY  (MULT_LATENCY),
        .PRODUCT_WIDTH (PRODUCT_WIDTH)
    ) i_tap_accumulator (
        .clk       (clk),
        .rst_n     (rst_n),
        .window    (window),
        .phase     (phase),
        .issue     (issue),
        .issue_eol (issue_eol),
        .pix_out   (pix_out)
    );

endmodule

/* hw/phase_counter.sv */
`timescale 1ns/1ns

module phase_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     clear,
    output bicubic_coef_pkg::phase_t phase,
    output logic                     phase_last
);

    import bicubic_coef_pkg::*;

    localparam phase_t LAST_PHASE = phase_t'(NUM_PHASES - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (clear) begin
            phase <= '0;
        end else if (run) begin
            if (phase == LAST_PHASE) begin
                phase <= '0;  // wraps straight into the next interval.
            end else begin
                phase <= phase + phase_t'(1);
            end
        end
    end

    assign phase_last = (phase == LAST_PHASE);

    a_phase_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        phase <= LAST_PHASE
    ) else $error("phase_counter: phase %0d is out of range.", phase);

endmodule

/* hw/tap_accumulator.sv */
`timescale 1ns/1ns

module tap_accumulator #(
    parameter int MULT_LATENCY  = 2,
    parameter int PRODUCT_WIDTH = 24
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  line_stream_pkg::window_s    window,
    input  bicubic_coef_pkg::phase_t    phase,
    input  logic                        issue,
    input  logic                        issue_eol,
    output line_stream_pkg::pixel_out_s pix_out
);

    import bicubic_coef_pkg::*;
    import line_stream_pkg::*;

    localparam int OPERAND_W  = PRODUCT_WIDTH - 8;
    localparam int SUM_W      = PRODUCT_WIDTH + 2;  // headroom for four products.
    localparam int ROUND_BIAS = 1 << (FRAC_BITS - 1);
    localparam int PIX_MAX    = (1 << PIXEL_W) - 1;

    // travels beside the multipliers so it lines up with their products.
    typedef struct packed {
        logic   valid;
        logic   eol;
        logic   bypass;
        pixel_t left;
    } side_s;

    tap_codes_t                     taps;
    coef_code_t                     code    [NUM_TAPS];
    pixel_t                         tap_pix [NUM_TAPS];
    logic signed [OPERAND_W-1:0]    operand [NUM_TAPS];
    logic signed [PRODUCT_WIDTH-1:0] product [NUM_TAPS];
    side_s                          side_in;
    side_s                          side_d;
    logic signed [SUM_W-1:0]        sum;
    logic signed [SUM_W-1:0]        rounded;
    logic signed [SUM_W-1:0]        shifted;
    pixel_t                         clipped;

    assign taps    = phase_taps(phase);
    assign code[0] = taps.tap0;
    assign code[1] = taps.tap1;
    assign code[2] = taps.tap2;
    assign code[3] = taps.tap3;

    assign tap_pix[0] = window.w0;
    assign tap_pix[1] = window.w1;
    assign tap_pix[2] = window.w2;
    assign tap_pix[3] = window.w3;

    generate
        for (genvar t = 0; t < NUM_TAPS; t++) begin : g_tap
            assign operand[t] = OPERAND_W'(tap_pix[t]);  // pixels are unsigned, zero extend.

            bicubic_mult_config #(
                .MULT_LATENCY  (MULT_LATENCY),
                .PRODUCT_WIDTH (PRODUCT_WIDTH)
            ) i_bicubic_mult_config (
                .clk     (clk),
                .code    (code[t]),
                .pixel   (operand[t]),
                .product (product[t])
            );
        end

        if (MULT_LATENCY == 1) begin : g_side_comb
            assign side_d = side_in;
        end else begin : g_side_pipe
            side_s side_pipe [MULT_LATENCY-1];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < MULT_LATENCY - 1; i++) begin
                        side_pipe[i] <= '0;
                    end
                end else begin
                    side_pipe[0] <= side_in;
                    for (int i = 1; i < MULT_LATENCY - 1; i++) begin
                        side_pipe[i] <= side_pipe[i-1];
                    end
                end
            end

            assign side_d = side_pipe[MULT_LATENCY-2];
        end
    endgenerate

    assign side_in = '{valid: issue, eol: issue_eol, bypass: (phase == '0), left: window.w1};

    always_comb begin
        sum     = product[0] + product[1] + product[2] + product[3];
        rounded = sum + SUM_W'(ROUND_BIAS);
        shifted = rounded >>> FRAC_BITS;
        if (shifted < 0) begin
            clipped = '0;                 // undershoot next to a sharp edge.
        end else if (shifted > SUM_W'(PIX_MAX)) begin
            clipped = pixel_t'(PIX_MAX);
        end else begin
            clipped = shifted[PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_out <= '0;
        end else begin
            pix_out.valid <= side_d.valid;
            pix_out.eol   <= side_d.valid && side_d.eol;
            pix_out.data  <= side_d.bypass ? side_d.left : clipped;  // phase 0 copies w1.
        end
    end

endmodule

/* hw/tap_window.sv */
`timescale 1ns/1ns

module tap_window (
    input  logic                     clk,
    input  logic                     rst_n,
    input  line_stream_pkg::pixel_t  pixel,
    input  logic                     load_sol,
    input  logic                     shift_pixel,
    input  logic                     shift_rep,
    output line_stream_pkg::window_s window
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window <= '0;
        end else if (load_sol) begin
            // the first pixel also stands in for the missing left neighbours.
            window.w1 <= pixel;
            window.w2 <= pixel;
            window.w3 <= pixel;
        end else if (shift_pixel || shift_rep) begin
            window.w0 <= window.w1;
            window.w1 <= window.w2;
            window.w2 <= window.w3;
            window.w3 <= shift_pixel ? pixel : window.w3;  // a flush repeats the right edge.
        end
    end

    // the controller sequences these strobes, never more than one per cycle.
    a_one_control : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({load_sol, shift_pixel, shift_rep})
    ) else $error("tap_window: more than one window control in the same cycle.");

endmodule

/* hw/upscale_ctrl.sv */
`timescale 1ns/1ns

module upscale_ctrl #(
    parameter int MULT_LATENCY = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  line_stream_pkg::pixel_in_s pix_in,
    input  logic                       phase_last,
    input  bicubic_coef_pkg::phase_t   phase,
    output logic                       load_sol,
    output logic                       shift_pixel,
    output logic                       shift_rep,
    output logic                       run,
    output logic                       clear,
    output logic                       issue,
    output logic                       issue_eol,
    output logic                       busy
);

    import bicubic_coef_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FILL,
        S_WAIT,
        S_ISSUE,
        S_FLUSH,
        S_DRAIN
    } state_e;

    state_e     state;
    state_e     state_next;
    logic [1:0] pix_cnt;    // accepted pixels, saturates at 3.
    logic [1:0] flush_cnt;  // flush rounds started.
    logic       eol_seen;
    logic       drain_done;

    assign load_sol    = (state == S_IDLE) && pix_in.valid && pix_in.sol;
    assign shift_pixel = pix_in.valid && (state inside {S_FILL, S_WAIT, S_ISSUE});
    assign shift_rep   = (state == S_FLUSH);
    assign issue       = (state == S_ISSUE);
    assign issue_eol   = issue && phase_last && eol_seen && (flush_cnt == 2'd2);
    assign drain_done  = (state == S_DRAIN) && (phase == phase_t'(MULT_LATENCY - 1));
    assign run         = issue || (state == S_DRAIN);  // the counter also times the drain.
    assign clear       = load_sol || drain_done;
    assign busy        = (state != S_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (load_sol) begin
                    state_next = S_FILL;
                end
            end
            S_FILL: begin
                if (shift_pixel) begin
                    if (pix_in.eol && pix_cnt == 2'd1) begin
                        state_next = S_FLUSH;  // two pixel line, only flush rounds follow.
                    end else if (pix_cnt == 2'd2) begin
                        state_next = S_ISSUE;  // the third pixel completes the window.
                    end
                end
            end
            S_WAIT: begin
                if (shift_pixel) begin
                    state_next = S_ISSUE;
                end
            end
            S_ISSUE: begin
                if (phase_last) begin
                    if (shift_pixel) begin
                        state_next = S_ISSUE;  // back to back with the next interval.
                    end else if (!eol_seen) begin
                        state_next = S_WAIT;
                    end else if (flush_cnt == 2'd2) begin
                        state_next = S_DRAIN;
                    end else begin
                        state_next = S_FLUSH;
                    end
                end
            end
            S_FLUSH: state_next = S_ISSUE;
            S_DRAIN: begin
                if (drain_done) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            pix_cnt   <= '0;
            flush_cnt <= '0;
            eol_seen  <= 1'b0;
        end else begin
            state <= state_next;
            if (load_sol) begin
                pix_cnt   <= 2'd1;
                flush_cnt <= 2'd0;
                eol_seen  <= 1'b0;
            end else begin
                if (shift_pixel && pix_cnt != 2'd3) begin
                    pix_cnt <= pix_cnt + 2'd1;
                end
                if (shift_pixel && pix_in.eol) begin
                    eol_seen <= 1'b1;
                end
                if (shift_rep) begin
                    flush_cnt <= flush_cnt + 2'd1;
                end
            end
        end
    end

    // one interval takes five issue cycles, so strobes closer than that would overlap.
    a_strobe_spacing : assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_in.valid |-> !($past(pix_in.valid, 1) || $past(pix_in.valid, 2) ||
                           $past(pix_in.valid, 3) || $past(pix_in.valid, 4))
    ) else $error("upscale_ctrl: pixel strobes closer than 5 cycles.");

    a_sol_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_in.valid && pix_in.sol |-> !busy
    ) else $error("upscale_ctrl: start of line while the previous line is busy.");

    a_line_length : assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_in.valid && pix_in.sol |-> !pix_in.eol
    ) else $error("upscale_ctrl: line shorter than 2 pixels.");

endmodule

/* sim.f */
hw/bicubic_coef_pkg.sv
hw/line_stream_pkg.sv
hw/bicubic_mult_config.sv
hw/tap_window.sv
hw/phase_counter.sv
hw/upscale_ctrl.sv
hw/tap_accumulator.sv
hw/line_upscaler_top.sv
verif/tb_line_upscaler.sv

/* verif/tb_line_upscaler.sv */
`timescale 1ns/1ns

module tb_line_upscaler #(
    parameter int MULT_LATENCY = 2
);

    import line_stream_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RAND_LINES      = 8;
    localparam int MAX_PIXELS      = 12 + 12 + RAND_LINES * 20 + 16 + 12 + 4 * 2 + 3 + 10;
    localparam int NUM_LINES       = 2 + RAND_LINES + 2 + 4 + 2;
    localparam int WATCHDOG_CYCLES = MAX_PIXELS * 8 + NUM_LINES * 100 + 300;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // weights in 1/2048 for phases 1 to 4, window slots w0 to w3.
    localparam int WEIGHTS [4][4] = '{
        '{-21, 1981, 235, -147},
        '{-135, 1535, 873, -225},
        '{-225, 873, 1535, -135},
        '{-147, 235, 1981, -21}
    };

    typedef struct packed {
        logic   eol;
        pixel_t data;
    } expect_s;

    logic        clk;
    logic        rst_n;
    pixel_in_s   pix_in;
    pixel_out_s  pix_out;
    logic        busy;
    expect_s     exp_q [$];
    int          len_q [$];  // outputs expected for each pending line.
    logic [31:0] lfsr;
    logic        discard_out;  // outputs of a line that reset cuts off have no expected values.
    int          errors;
    int          checks;
    int          out_cnt;
    int          tests_run;
    int          tests_failed;

    line_upscaler_top #(
        .MULT_LATENCY (MULT_LATENCY)
    ) i_line_upscaler_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_in  (pix_in),
        .pix_out (pix_out),
        .busy    (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_POLY;
        end
        return next;
    endfunction

    function automatic int rand_bits(input int nbits);
        int value;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);  // one step per bit taken.
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // builds the 5N outputs of a line with the edge pixels repeated at both ends.
    function automatic void ref_line(input pixel_t pix [$]);
        expect_s item;
        int      last;
        int      idx;
        int      sum;
        int      value;
        last = pix.size() - 1;
        for (int k = 0; k <= last; k++) begin
            item.eol  = 1'b0;
            item.data = pix[k];  // phase 0 is the left pixel itself.
            exp_q.push_back(item);
            for (int p = 1; p < 5; p++) begin
                sum = 0;
                for (int t = 0; t < 4; t++) begin
                    idx = k + t - 1;
                    idx = (idx < 0) ? 0 : ((idx > last) ? last : idx);
                    sum += WEIGHTS[p-1][t] * int'(pix[idx]);
                end
                value     = (sum + 1024) >>> 11;
                value     = (value < 0) ? 0 : ((value > 255) ? 255 : value);
                item.eol  = (k == last) && (p == 4);
                item.data = pixel_t'(value);
                exp_q.push_back(item);
            end
        end
        len_q.push_back(5 * pix.size());
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin : monitor
        expect_s exp;
        if (!rst_n) begin
            out_cnt = 0;
        end else if (pix_out.valid && !discard_out) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t ns: the DUT gave an extra output that no line expects.",
                         $time);
            end else begin
                exp = exp_q.pop_front();
                check_value(pix_out.data, exp.data, "output pixel");
                check_value(pix_out.eol, exp.eol, "output eol flag");
            end
            if (pix_out.eol) begin
                if (len_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t ns: end of line seen with no line pending.", $time);
                end else begin
                    check_value(out_cnt, len_q.pop_front(), "outputs in line");
                end
                out_cnt = 0;
            end
        end
    end

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drive_pixel(input pixel_t data, input logic sol, input logic eol,
                               input int gap);
        pix_in = '{valid: 1'b1, sol: sol, eol: eol, data: data};
        repeat (gap) begin
            @(posedge clk);
            #2;
            pix_in = '0;
        end
    endtask

    task automatic send_line(input pixel_t pix [$]);
        int gap;
        wait_idle();  // a new line may only start once the previous one has drained.
        for (int i = 0; i < pix.size(); i++) begin
            gap = 5 + rand_bits(2);
            drive_pixel(pix[i], i == 0, i == pix.size() - 1, gap);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        wait_idle();
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t ns: %0d expected outputs never appeared.", $time, exp_q.size());
            exp_q.delete();
            len_q.delete();
        end
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: the run timed out after %0d cycles.", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        pixel_t  line [$];
        expect_s item;
        int      mark;
        int      len;
        clk          = 1'b0;
        rst_n        = 1'b0;
        pix_in       = '0;
        lfsr         = 32'd93825;
        discard_out  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;  // a flat line must stay flat since every phase sums to 2048.
        line.delete();
        for (int i = 0; i < 12; i++) begin
            line.push_back(8'd137);
        end
        for (int i = 0; i < 60; i++) begin
            item.eol  = (i == 59);
            item.data = 8'd137;
            exp_q.push_back(item);
        end
        len_q.push_back(60);
        send_line(line);
        finish_test("constant_line", mark);

        mark = errors;
        line.delete();
        for (int i = 0; i < 12; i++) begin
            line.push_back(pixel_t'(i * 21));
        end
        ref_line(line);
        send_line(line);
        finish_test("phase0_copy", mark);

        mark = errors;
        for (int n = 0; n < RAND_LINES; n++) begin
            len = 2 + rand_bits(5) % 19;
            line.delete();
            for (int i = 0; i < len; i++) begin
                line.push_back(pixel_t'(rand_bits(8)));
            end
            ref_line(line);
            send_line(line);
        end
        finish_test("random_lines", mark);

        mark = errors;
        line.delete();
        for (int i = 0; i < 16; i++) begin
            line.push_back((i % 2 == 0) ? 8'd0 : 8'd255);
        end
        ref_line(line);
        send_line(line);
        line.delete();
        for (int i = 0; i < 12; i++) begin
            line.push_back((i < 6) ? 8'd0 : 8'd255);  // one step edge.
        end
        ref_line(line);
        send_line(line);
        finish_test("edges_clip", mark);

        mark = errors;
        for (int n = 0; n < 4; n++) begin
            line.delete();
            line.push_back(pixel_t'(rand_bits(8)));
            line.push_back(pixel_t'(rand_bits(8)));
            ref_line(line);
            send_line(line);
        end
        finish_test("short_back_to_back", mark);

        mark = errors;
        wait_idle();
        discard_out = 1'b1;
        // the third pixel completes the window, so the first interval is on the output at reset.
        drive_pixel(pixel_t'(rand_bits(8)), 1'b1, 1'b0, 6);
        drive_pixel(pixel_t'(rand_bits(8)), 1'b0, 1'b0, 6);
        drive_pixel(pixel_t'(rand_bits(8)), 1'b0, 1'b0, 5);
        check_value(pix_out.valid, 1, "output valid before reset");
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n       = 1'b1;
        discard_out = 1'b0;
        @(posedge clk);
        #2;
        check_value(busy, 0, "busy after reset");
        check_value(pix_out.valid, 0, "output valid after reset");
        line.delete();
        for (int i = 0; i < 10; i++) begin
            line.push_back(pixel_t'(rand_bits(8)));
        end
        ref_line(line);
        send_line(line);
        finish_test("reset_mid_line", mark);

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
